// ==== hdl/credit_link_pkg.sv ====
/* Default parameter values for the credit link
   and the encoding of the link fault report. */

package credit_link_pkg;

  // Number of flows sharing one credit sender.
  localparam int def_num_flows = 4;

  // Data width of each item in bits.
  localparam int def_width = 16;

  // Receiver buffer depth, which is also the largest credit count.
  localparam int def_max_credit = 8;

  // Sticky link fault report from the monitor.
  // Bit 0 flags an overrun and bit 1 a spurious credit.
  typedef enum logic [1:0] {
    // No fault seen since reset.
    err_none            = 2'b00,
    // Item sent while the sender model held no credit.
    err_overrun         = 2'b01,
    // Credit returned that the sender never spent.
    err_spurious_credit = 2'b10,
    // Both faults seen.
    err_both            = 2'b11
  } link_err_e;

endpackage : credit_link_pkg

// ==== hdl/credit_if.sv ====
/* Credit link between sender and receiver,
   with sender, receiver and monitor modports. */

`timescale 1ns/1ps

interface credit_if #(
  // Number of flows multiplexed onto the link.
  parameter int NumFlows = 1,
  // Data width in bits.
  parameter int Width = 1
);

  localparam int FlowWidth = (NumFlows == 1) ? 1 : $clog2(NumFlows);

  // One-cycle strobe, one item per strobe, no ready.
  logic                 link_valid;
  // Flow that the item came from.
  logic [FlowWidth-1:0] link_flow;
  // Item payload.
  logic [Width-1:0]     link_data;
  // One-cycle pulse, one credit back to the sender.
  logic                 link_credit;

  // Sender puts items on the link and collects credits.
  modport sender (output link_valid, output link_flow, output link_data, input link_credit);

  // Receiver takes every strobe and hands back credits.
  modport receiver (input link_valid, input link_flow, input link_data, output link_credit);

  // Monitor only observes.
  modport monitor (input link_valid, input link_flow, input link_data, input link_credit);

endinterface : credit_if

// ==== hdl/credit_sender.sv ====
/* Credit sender: round-robin arbiter over the push flows,
   credit counter with reset-time initial value and withhold. */

`timescale 1ns/1ps

module credit_sender #(
  // Number of push flows.
  parameter int NumFlows = 1,
  // Data width in bits.
  parameter int Width = 1,
  // Largest credit count the receiver can back.
  parameter int MaxCredit = 1,

  localparam int CounterWidth = $clog2(MaxCredit + 1),
  localparam int FlowWidth    = (NumFlows == 1) ? 1 : $clog2(NumFlows)
) (
  input  logic                           clk,
  input  logic                           rst,

  // Counter load value, sampled every cycle of reset.
  input  logic [CounterWidth-1:0]        credit_initial,
  // Credits kept out of circulation.
  input  logic [CounterWidth-1:0]        credit_withhold,

  // Ready/valid push side, one lane per flow.
  input  logic [NumFlows-1:0]            push_valid,
  output logic [NumFlows-1:0]            push_ready,
  input  logic [NumFlows-1:0][Width-1:0] push_data,

  // Count minus withhold, floored at zero.
  output logic [CounterWidth-1:0]        credit_available,

  credit_if.sender                       link
);

  // Flow searched first on the next grant.
  logic [FlowWidth-1:0]    rr_ptr;
  logic [FlowWidth-1:0]    grant_idx;
  logic                    grant_found;
  logic                    push_xfer;
  logic [CounterWidth-1:0] credit_count;

  // Withheld credits are not spendable.
  assign credit_available = (credit_count > credit_withhold) ?
                            (credit_count - credit_withhold) : '0;

  // First valid flow at or after the pointer, only while a credit is spendable.
  always_comb begin
    int cand;
    grant_found = 1'b0;
    grant_idx   = '0;
    for (int i = 0; i < NumFlows; i++) begin
      cand = int'(rr_ptr) + i;
      if (cand >= NumFlows) begin
        cand = cand - NumFlows;
      end
      if (!grant_found && push_valid[cand] && (credit_available != '0)) begin
        grant_found = 1'b1;
        grant_idx   = FlowWidth'(cand);
      end
    end
  end

  // One-hot ready on the granted flow.
  always_comb begin
    push_ready = '0;
    if (grant_found) begin
      push_ready[grant_idx] = 1'b1;
    end
  end

  assign push_xfer = |(push_valid & push_ready);

  // Pointer moves one past the granted flow after each transfer.
  always_ff @(posedge clk) begin
    if (rst) begin
      rr_ptr <= '0;
    end else if (push_xfer) begin
      if (grant_idx == FlowWidth'(NumFlows - 1)) begin
        rr_ptr <= '0;
      end else begin
        rr_ptr <= grant_idx + 1'b1;
      end
    end
  end

  // One credit spent per transfer; a returned credit counts on the same edge.
  always_ff @(posedge clk) begin
    if (rst) begin
      credit_count <= credit_initial;
    end else begin
      credit_count <= credit_count + CounterWidth'(link.link_credit)
                                   - CounterWidth'(push_xfer);
    end
  end

  // Strobe goes out the cycle after the push transfer.
  always_ff @(posedge clk) begin
    if (rst) begin
      link.link_valid <= 1'b0;
    end else begin
      link.link_valid <= push_xfer;
    end
  end

  // Payload captured from the granted lane.
  always_ff @(posedge clk) begin
    if (push_xfer) begin
      link.link_flow <= grant_idx;
      link.link_data <= push_data[grant_idx];
    end
  end

  // Receiver must never return more credits than it can hold.
  credit_count_bound_a: assert property (@(posedge clk) disable iff (rst)
    credit_count <= CounterWidth'(MaxCredit))
    else $error("credit count above MaxCredit");

endmodule : credit_sender

// ==== hdl/credit_receiver.sv ====
/* Credit receiver: circular buffer of MaxCredit items,
   output drain and one credit return per drained item. */

`timescale 1ns/1ps

module credit_receiver #(
  // Number of flows carried on the link.
  parameter int NumFlows = 1,
  // Data width in bits.
  parameter int Width = 1,
  // Buffer depth, matching the sender credit maximum.
  parameter int MaxCredit = 1,

  localparam int FlowWidth = (NumFlows == 1) ? 1 : $clog2(NumFlows)
) (
  input  logic                 clk,
  input  logic                 rst,

  credit_if.receiver           link,

  // Ready/valid output side.
  output logic                 out_valid,
  input  logic                 out_ready,
  output logic [Width-1:0]     out_data,
  output logic [FlowWidth-1:0] out_flow
);

  localparam int AddrWidth  = (MaxCredit == 1) ? 1 : $clog2(MaxCredit);
  localparam int CountWidth = $clog2(MaxCredit + 1);

  // Item storage.
  logic [Width-1:0]     buf_data [MaxCredit];
  logic [FlowWidth-1:0] buf_flow [MaxCredit];

  logic [AddrWidth-1:0]  wr_ptr;
  logic [AddrWidth-1:0]  rd_ptr;
  logic [CountWidth-1:0] count;
  logic [CountWidth-1:0] count_next;
  logic                  pop;

  // Advance a pointer with wrap at the buffer depth.
  function automatic logic [AddrWidth-1:0] next_addr(input logic [AddrWidth-1:0] addr);
    if (addr == AddrWidth'(MaxCredit - 1)) begin
      return '0;
    end
    return addr + 1'b1;
  endfunction

  assign pop        = out_valid & out_ready;
  assign count_next = count + CountWidth'(link.link_valid) - CountWidth'(pop);

  // Every strobe is written, there is no back-pressure on the link.
  always_ff @(posedge clk) begin
    if (link.link_valid) begin
      buf_data[wr_ptr] <= link.link_data;
      buf_flow[wr_ptr] <= link.link_flow;
    end
  end

  // Pointers and occupancy.
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (link.link_valid) begin
        wr_ptr <= next_addr(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= next_addr(rd_ptr);
      end
      count <= count_next;
    end
  end

  // Valid comes from a flop, so it rises the cycle after the write.
  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= (count_next != '0);
    end
  end

  // Oldest entry, read straight from storage flops.
  assign out_data = buf_data[rd_ptr];
  assign out_flow = buf_flow[rd_ptr];

  // Credit goes back the cycle after the item leaves.
  always_ff @(posedge clk) begin
    if (rst) begin
      link.link_credit <= 1'b0;
    end else begin
      link.link_credit <= pop;
    end
  end

  // Sender credits must keep the buffer from overflowing.
  no_write_when_full_a: assert property (@(posedge clk) disable iff (rst)
    link.link_valid |-> (count < CountWidth'(MaxCredit)))
    else $error("link strobe into a full buffer");

  // Stalled output keeps its item.
  out_hold_a: assert property (@(posedge clk) disable iff (rst)
    out_valid && !out_ready |=> out_valid && $stable(out_data) && $stable(out_flow))
    else $error("output changed while stalled");

endmodule : credit_receiver

// ==== hdl/credit_link_monitor.sv ====
/* Link monitor: independent credit model of the sender,
   sticky fault report and matching assertions. */

`timescale 1ns/1ps

module credit_link_monitor
  import credit_link_pkg::*;
#(
  // Number of flows on the link.
  parameter int NumFlows = 1,
  // Data width in bits.
  parameter int Width = 1,
  // Largest credit count.
  parameter int MaxCredit = 1,

  localparam int CountWidth = $clog2(MaxCredit + 1)
) (
  input  logic                  clk,
  input  logic                  rst,
  // Same load value the sender samples in reset.
  input  logic [CountWidth-1:0] credit_initial,
  credit_if.monitor             link,
  output link_err_e             link_error
);

  localparam int SumWidth = CountWidth + 1;

  // Model runs one strobe behind the sender counter.
  logic [CountWidth-1:0] model_count;
  // Credits in circulation since reset.
  logic [CountWidth-1:0] model_init;
  logic [SumWidth-1:0]   model_after;
  logic                  overrun;
  logic                  spent;
  logic                  spurious;
  logic [1:0]            err_bits;

  // A strobe with no model credit left.
  assign overrun = link.link_valid && (model_count == '0);
  assign spent   = link.link_valid && !overrun;

  // Count after this cycle, one bit wider to catch a climb past the initial value.
  assign model_after = SumWidth'(model_count) + SumWidth'(link.link_credit) - SumWidth'(spent);
  assign spurious    = link.link_credit && (model_after > SumWidth'(model_init));

  // Faulty credits are dropped so the model stays in range.
  always_ff @(posedge clk) begin
    if (rst) begin
      model_count <= credit_initial;
      model_init  <= credit_initial;
    end else if (spurious) begin
      model_count <= model_count - CountWidth'(spent);
    end else begin
      model_count <= model_after[CountWidth-1:0];
    end
  end

  // Sticky until reset.
  always_ff @(posedge clk) begin
    if (rst) begin
      err_bits <= '0;
    end else begin
      err_bits <= err_bits | {spurious, overrun};
    end
  end

  assign link_error = link_err_e'(err_bits);

  link_overrun_a: assert property (@(posedge clk) disable iff (rst)
    link.link_valid |-> (model_count != '0))
    else $error("link overrun, strobe flow %0d", link.link_flow);

  link_spurious_credit_a: assert property (@(posedge clk) disable iff (rst)
    link.link_credit |-> (model_after <= SumWidth'(model_init)))
    else $error("spurious credit returned");

endmodule : credit_link_monitor

// ==== hdl/credit_link_top.sv ====
/* Credit link top level: sender, link interface,
   receiver and link monitor. */

`timescale 1ns/1ps

module credit_link_top
  import credit_link_pkg::*;
#(
  // Number of push flows.
  parameter int NumFlows = def_num_flows,
  // Data width in bits.
  parameter int Width = def_width,
  // Buffer depth and credit maximum.
  parameter int MaxCredit = def_max_credit,

  localparam int CounterWidth = $clog2(MaxCredit + 1),
  localparam int FlowWidth    = (NumFlows == 1) ? 1 : $clog2(NumFlows)
) (
  input  logic                           clk,
  input  logic                           rst,

  // Flow side.
  input  logic [NumFlows-1:0]            push_valid,
  output logic [NumFlows-1:0]            push_ready,
  input  logic [NumFlows-1:0][Width-1:0] push_data,

  // Output side.
  output logic                           out_valid,
  input  logic                           out_ready,
  output logic [Width-1:0]               out_data,
  output logic [FlowWidth-1:0]           out_flow,

  // Credit control.
  input  logic [CounterWidth-1:0]        credit_initial,
  input  logic [CounterWidth-1:0]        credit_withhold,

  // Observation.
  output logic [CounterWidth-1:0]        credit_available,
  output link_err_e                      link_error
);

  // Wire between the two sides.
  credit_if #(.NumFlows(NumFlows), .Width(Width)) link_bus ();

  credit_sender #(.NumFlows(NumFlows), .Width(Width), .MaxCredit(MaxCredit)) u_sender (
    .clk              (clk),
    .rst              (rst),
    .credit_initial   (credit_initial),
    .credit_withhold  (credit_withhold),
    .push_valid       (push_valid),
    .push_ready       (push_ready),
    .push_data        (push_data),
    .credit_available (credit_available),
    .link             (link_bus)
  );

  credit_receiver #(.NumFlows(NumFlows), .Width(Width), .MaxCredit(MaxCredit)) u_receiver (
    .clk       (clk),
    .rst       (rst),
    .link      (link_bus),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_data  (out_data),
    .out_flow  (out_flow)
  );

  // Watches the link only.
  credit_link_monitor #(.NumFlows(NumFlows), .Width(Width), .MaxCredit(MaxCredit)) u_monitor (
    .clk            (clk),
    .rst            (rst),
    .credit_initial (credit_initial),
    .link           (link_bus),
    .link_error     (link_error)
  );

endmodule : credit_link_top

// ==== sim/credit_link_checker.sv ====
/* Testbench checker: reference queue and credit model,
   per-cycle comparison against the DUT ports and transfer counts. */

`timescale 1ns/1ps

module credit_link_checker
  import credit_link_pkg::*;
#(
  parameter int NumFlows = 1,
  parameter int Width = 1,
  parameter int MaxCredit = 1,

  localparam int CounterWidth = $clog2(MaxCredit + 1),
  localparam int FlowWidth    = (NumFlows == 1) ? 1 : $clog2(NumFlows)
) (
  input  logic                           clk,
  input  logic                           rst,
  input  logic [NumFlows-1:0]            push_valid,
  input  logic [NumFlows-1:0]            push_ready,
  input  logic [NumFlows-1:0][Width-1:0] push_data,
  input  logic                           out_valid,
  input  logic                           out_ready,
  input  logic [Width-1:0]               out_data,
  input  logic [FlowWidth-1:0]           out_flow,
  input  logic [CounterWidth-1:0]        credit_initial,
  input  logic [CounterWidth-1:0]        credit_withhold,
  input  logic [CounterWidth-1:0]        credit_available,
  input  link_err_e                      link_error,
  // Test control from the testbench top.
  input  logic                           test_start,
  input  logic                           count_check,
  input  int                             count_expect,
  output int                             err_count,
  output int                             link_faults,
  output int                             push_xfers,
  output int                             pending
);

  // Items in flight, flow index above data.
  logic [FlowWidth+Width-1:0] model_q [$];
  int   model_credits = 0;
  int   model_ptr     = 0;
  logic credit_due    = 1'b0;
  // Model pushed an item on the previous edge, not yet in the buffer.
  logic pushed_prev   = 1'b0;
  logic was_rst       = 1'b0;
  int   errs          = 0;
  int   faults        = 0;
  int   pushes        = 0;
  // Transfers seen on the DUT push handshake.
  int   dut_pushes    = 0;
  int   outs          = 0;
  int   queued        = 0;

  assign err_count   = errs;
  assign link_faults = faults;
  assign push_xfers  = pushes;
  assign pending     = queued;

  // Count minus withhold, never below zero.
  function automatic int spendable(input int count, input int withhold);
    return (count > withhold) ? count - withhold : 0;
  endfunction

  // First valid flow at or after the pointer, or -1 with no grant.
  function automatic int expected_grant(input logic [NumFlows-1:0] valid, input int ptr,
                                        input int avail);
    int idx;
    if (avail == 0) begin
      return -1;
    end
    for (int i = 0; i < NumFlows; i++) begin
      idx = (ptr + i) % NumFlows;
      if (valid[idx]) begin
        return idx;
      end
    end
    return -1;
  endfunction

  task automatic compare_value(input string name, input int expected, input int actual);
    if (expected != actual) begin
      $display("ERR t=%0t %s expected 0x%0h got 0x%0h", $time, name, expected, actual);
      errs++;
    end
  endtask

  always @(posedge clk) begin
    int avail;
    int grant;
    logic [NumFlows-1:0] exp_ready;
    logic [FlowWidth+Width-1:0] head;
    avail = spendable(model_credits, int'(credit_withhold));
    if (rst) begin
      // Registers are settled from the second reset edge on.
      if (was_rst) begin
        compare_value("push_ready", 0, int'(push_ready));
        compare_value("out_valid", 0, int'(out_valid));
        compare_value("link_error", 0, int'(link_error));
        compare_value("credit_available", avail, int'(credit_available));
      end
      model_q.delete();
      model_credits = int'(credit_initial);
      model_ptr     = 0;
      credit_due    = 1'b0;
      pushed_prev   = 1'b0;
    end else begin
      compare_value("credit_available", avail, int'(credit_available));
      // An item shows on the output two edges after its push.
      compare_value("out_valid", int'((model_q.size() - int'(pushed_prev)) > 0),
                    int'(out_valid));
      if (link_error != err_none) begin
        faults++;
      end
      compare_value("link_error", 0, int'(link_error));
      grant     = expected_grant(push_valid, model_ptr, avail);
      exp_ready = '0;
      if (grant >= 0) begin
        exp_ready[grant] = 1'b1;
      end
      compare_value("push_ready", int'(exp_ready), int'(push_ready));
      if (|(push_valid & push_ready)) begin
        dut_pushes++;
      end
      // A drained item gives its credit back one edge later.
      if (credit_due) begin
        model_credits++;
      end
      if (grant >= 0) begin
        model_q.push_back({FlowWidth'(grant), push_data[grant]});
        model_credits--;
        model_ptr = (grant + 1) % NumFlows;
        pushes++;
      end
      pushed_prev = (grant >= 0);
      credit_due  = out_valid && out_ready;
      if (credit_due) begin
        if (model_q.size() == 0) begin
          $display("t=%0t output transfer with no item waiting in the model queue", $time);
          errs++;
        end else begin
          head = model_q.pop_front();
          compare_value("out_flow", int'(head[Width +: FlowWidth]), int'(out_flow));
          compare_value("out_data", int'(head[Width-1:0]), int'(out_data));
        end
        outs++;
      end
    end
    was_rst = rst;
    if (test_start) begin
      pushes     = 0;
      dut_pushes = 0;
      outs       = 0;
    end
    // Once drained, every push must have left the output.
    if (count_check) begin
      compare_value("push transfers", count_expect, dut_pushes);
      if (model_q.size() == 0) begin
        compare_value("output transfers", dut_pushes, outs);
      end
    end
    queued = model_q.size();
  end

endmodule : credit_link_checker

// ==== sim/credit_link_tb.sv ====
/* Testbench top: clock, reset, seeded random stimulus,
   test sequence, result lines and cycle limit. */

`timescale 1ns/1ps

module credit_link_tb
  import credit_link_pkg::*;
();

  localparam int NumFlows     = def_num_flows;
  localparam int Width        = def_width;
  localparam int MaxCredit    = def_max_credit;
  localparam int CounterWidth = $clog2(MaxCredit + 1);
  localparam int FlowWidth    = (NumFlows == 1) ? 1 : $clog2(NumFlows);
  localparam int DataItems    = 300;
  localparam int RotateItems  = 40;
  // Items over all tests, both credit batches taken at full size.
  localparam int TotalItems   = DataItems + 2 * MaxCredit + RotateItems;
  localparam int CycleLimit   = 20 * TotalItems + 200;

  logic                           clk = 1'b0;
  logic                           rst;
  logic [NumFlows-1:0]            push_valid;
  logic [NumFlows-1:0]            push_ready;
  logic [NumFlows-1:0][Width-1:0] push_data;
  logic                           out_valid;
  logic                           out_ready;
  logic [Width-1:0]               out_data;
  logic [FlowWidth-1:0]           out_flow;
  logic [CounterWidth-1:0]        credit_initial;
  logic [CounterWidth-1:0]        credit_withhold;
  logic [CounterWidth-1:0]        credit_available;
  link_err_e                      link_error;
  logic                           test_start;
  logic                           count_check;
  int                             count_expect;
  int                             err_count;
  int                             link_faults;
  int                             push_xfers;
  int                             pending;
  int cycles       = 0;
  int tests_run    = 0;
  int tests_failed = 0;
  int errs_seen    = 0;
  int test_credits;
  int hold;

  credit_link_top #(.NumFlows(NumFlows), .Width(Width), .MaxCredit(MaxCredit)) u_dut (.*);

  credit_link_checker #(.NumFlows(NumFlows), .Width(Width), .MaxCredit(MaxCredit))
    u_checker (.*);

  initial begin
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= CycleLimit) begin
      $display("run stopped after %0d cycles, test %0d never finished", cycles, tests_run + 1);
      $display("TEST FAILED");
      $finish;
    end
  end

  task automatic randomize_data();
    for (int i = 0; i < NumFlows; i++) begin
      push_data[i] = Width'($urandom);
    end
  endtask

  // Three reset cycles, then one idle cycle with the flows quiet.
  task automatic apply_reset(input int init);
    rst             = 1'b1;
    push_valid      = '0;
    out_ready       = 1'b0;
    credit_initial  = CounterWidth'(init);
    credit_withhold = '0;
    repeat (3) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
  endtask

  task automatic start_test();
    test_start = 1'b1;
    @(negedge clk);
    test_start = 1'b0;
  endtask

  task automatic check_count(input int expected);
    count_expect = expected;
    count_check  = 1'b1;
    @(negedge clk);
    count_check  = 1'b0;
  endtask

  // All flows push into a stalled output until the credits are gone.
  task automatic fill_until_empty();
    out_ready  = 1'b0;
    push_valid = '1;
    while (credit_available != '0) begin
      randomize_data();
      @(negedge clk);
    end
    // Ready has to stay low from here.
    repeat (MaxCredit) begin
      randomize_data();
      @(negedge clk);
    end
    push_valid = '0;
  endtask

  task automatic drain_to(input int target);
    push_valid = '0;
    out_ready  = 1'b1;
    while (pending != 0 || int'(credit_available) != target) begin
      @(negedge clk);
    end
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (err_count == errs_seen) begin
      $display("test %0d %s: pass", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: fail, %0d errors", tests_run, name, err_count - errs_seen);
    end
    errs_seen = err_count;
  endtask

  initial begin
    void'($urandom(96483));
    test_start   = 1'b0;
    count_check  = 1'b0;
    count_expect = 0;
    push_data    = '0;
    apply_reset(MaxCredit);
    finish_test("reset state");

    start_test();
    while (push_xfers < DataItems) begin
      push_valid = NumFlows'($urandom);
      out_ready  = ($urandom % 4) != 0;
      randomize_data();
      @(negedge clk);
    end
    drain_to(MaxCredit);
    check_count(DataItems);
    finish_test("data integrity");

    // Random credit budget, part of it withheld.
    test_credits = 1 + int'($urandom % MaxCredit);
    apply_reset(test_credits);
    credit_withhold = CounterWidth'($urandom % test_credits);
    hold = test_credits - int'(credit_withhold);
    start_test();
    fill_until_empty();
    check_count(hold);
    finish_test("credit limit");

    drain_to(hold);
    start_test();
    fill_until_empty();
    drain_to(hold);
    check_count(hold);
    finish_test("credit return");

    apply_reset(MaxCredit);
    start_test();
    push_valid = '1;
    out_ready  = 1'b1;
    while (push_xfers < RotateItems) begin
      randomize_data();
      @(negedge clk);
    end
    drain_to(MaxCredit);
    check_count(RotateItems);
    finish_test("round robin");

    tests_run++;
    if (link_faults == 0) begin
      $display("test %0d link health: pass", tests_run);
    end else begin
      tests_failed++;
      $display("test %0d link health: fail, %0d faulty cycles", tests_run, link_faults);
    end

    $display("%0d tests, %0d failed, %0d mismatches", tests_run, tests_failed, err_count);
    if (tests_failed == 0 && err_count == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule : credit_link_tb

// ==== credit_link.f ====
hdl/credit_link_pkg.sv
hdl/credit_if.sv
hdl/credit_sender.sv
hdl/credit_receiver.sv
hdl/credit_link_monitor.sv
hdl/credit_link_top.sv
sim/credit_link_checker.sv
sim/credit_link_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the credit link testbench with Verilator, run it and look for the pass line.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f credit_link.f --top-module credit_link_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

sim_output=$(./obj_dir/Vcredit_link_tb)
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_output" | grep -qx "TEST OK"; then
  exit 0
fi
exit 1
